// File: bench/tb_clk_gen.sv
/*
 * Testbench clock source
 */

module tb_clk_gen #(
  parameter int period = 100
) (
  output logic clk
);

  initial clk = 1'b0;
  always #(period / 2) clk = ~clk;

endmodule

// File: bench/tb_tx_frontend.sv
/*
 * Table-driven testbench for the transmit frontend
 * Packet driver, strobing radio model, response checker and watchdog
 */

module tb_tx_frontend;

  localparam logic [7:0] sr_addr = 8'd12;
  localparam int n_tests = 6;
  localparam int cycle_budget = 400;

  // Test table with one entry per test in each array
  // An underrun beat or extra eob packet of -1 means none
  string t_name [n_tests] = '{"untimed_burst", "timed_future", "late_command",
                              "underrun_next_burst", "underrun_next_packet",
                              "resp_backpressure"};
  int t_pol   [n_tests] = '{1, 1, 1, 2, 1, 1};
  int t_npkt  [n_tests] = '{3, 2, 2, 4, 3, 1};
  int t_len   [n_tests] = '{4, 3, 3, 4, 4, 5};
  int t_eobp  [n_tests] = '{-1, -1, -1, 2, -1, -1};
  int t_sa    [n_tests] = '{0, 1, 1, 0, 0, 0};
  int t_off   [n_tests] = '{0, 40, -5, 0, 0, 0};
  int t_ur    [n_tests] = '{-1, -1, -1, 2, 2, -1};
  int t_code  [n_tests] = '{1, 1, 8, 2, 2, 1};
  int t_seqp  [n_tests] = '{2, 1, 0, 0, 0, 0};
  int t_nresp [n_tests] = '{1, 1, 2, 2, 2, 1};
  int t_nsamp [n_tests] = '{12, 6, 3, 6, 10, 5};
  int t_stall [n_tests] = '{0, 0, 0, 0, 0, 6};

  logic clk, rst_n, clear, set_stb, tx_last, tx_valid, tx_ready;
  logic resp_last, resp_valid, resp_ready, run, strobe;
  logic [7:0] set_addr;
  logic [31:0] set_data;
  logic [127:0] tx_user, resp_user, held_user;
  logic [63:0] resp_data, held_data;
  radio_time_pkg::vita_time_t vita_time, send_time;
  radio_time_pkg::sid_t resp_sid;
  radio_time_pkg::sample_t tx_data, sample;
  radio_time_pkg::sample_t data_q[$];
  logic [31:0] rng = 32'heee8;
  int errors = 0, row_err, failed = 0, cyc = 0;

  tb_clk_gen #(.period(100)) clk_gen_i (.clk(clk));

  tx_frontend #(.sr_error_policy(sr_addr)) dut_i (
    .clk(clk), .rst_n(rst_n), .clear(clear), .vita_time(vita_time), .resp_sid(resp_sid),
    .set_stb(set_stb), .set_addr(set_addr), .set_data(set_data),
    .tx_data(tx_data), .tx_user(tx_user), .tx_last(tx_last), .tx_valid(tx_valid),
    .tx_ready(tx_ready), .resp_data(resp_data), .resp_user(resp_user),
    .resp_last(resp_last), .resp_valid(resp_valid), .resp_ready(resp_ready),
    .run(run), .sample(sample), .strobe(strobe)
  );

  function automatic logic [31:0] xorshift(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  task automatic compare(string test, string what, logic [63:0] exp, logic [63:0] act);
    if (exp !== act) begin
      $display("Mismatch in %s (%s): expected %0h, actual %0h", test, what, exp, act);
      row_err++;
    end
  endtask

  task automatic fail_note(string test, string text);
    $display("%s: %s", test, text);
    row_err++;
  endtask

  // Drives one beat along with the header of its packet
  // Only the first packet of a test carries a send time
  task automatic drive_beat(int t, int beat, int total);
    int p;
    p = beat / t_len[t];
    tx_valid = (beat < total);
    tx_data = (beat < total) ? data_q[beat] : '0;
    tx_last = ((beat % t_len[t]) == t_len[t] - 1);
    tx_user = '0;
    tx_user[tx_resp_pkg::tuser_seqnum_lsb +: 12] = 12'(t * 16 + p);
    tx_user[tx_resp_pkg::tuser_eob_bit] = (p == t_npkt[t] - 1) || (p == t_eobp[t]);
    if (p == 0 && t_sa[t] != 0) begin
      tx_user[tx_resp_pkg::tuser_send_at_bit] = 1'b1;
      tx_user[63:0] = send_time;
    end
  endtask

  task automatic run_test(int t);
    int total, beat, hold, nresp, nsamp, stall_left, first_code, last_code;
    logic xfer, seen, fall_pending, ur_done;
    row_err = 0;
    set_stb = 1'b1;
    set_data = 32'(t_pol[t]);
    @(posedge clk);
    #10 set_stb = 1'b0;
    total = t_npkt[t] * t_len[t];
    data_q.delete();
    for (int i = 0; i < total; i++) begin
      rng = xorshift(rng);
      data_q.push_back(rng);
    end
    send_time = radio_time_pkg::vita_time_t'(longint'(vita_time) + longint'(t_off[t]));
    {beat, hold, nresp, nsamp, first_code, last_code} = '0;
    {seen, fall_pending, ur_done} = '0;
    stall_left = t_stall[t];
    resp_ready = (stall_left == 0);
    drive_beat(t, 0, total);
    while (beat < total || nresp < t_nresp[t] || resp_valid) begin
      @(negedge clk);
      if (strobe && run && tx_ready && tx_valid) begin
        compare(t_name[t], "sample", 64'(data_q[beat]), 64'(sample));
        nsamp++;
      end
      if (strobe && run && !tx_valid) begin
        fail_note(t_name[t], "run stayed high on a strobe with no data");
      end
      if (t_sa[t] != 0 && run && vita_time < send_time) begin
        fail_note(t_name[t], "run rose before send time");
      end
      xfer = tx_valid && tx_ready;
      if (fall_pending && resp_valid) begin
        fail_note(t_name[t], "resp_valid stayed high after acceptance");
      end
      fall_pending = 1'b0;
      // Every response is a single beat
      compare(t_name[t], "resp_last", 64'(resp_valid), 64'(resp_last));
      if (resp_valid) begin
        if (!seen) begin
          held_data = resp_data;
          held_user = resp_user;
          seen = 1'b1;
        end
        compare(t_name[t], "held resp_data", held_data, resp_data);
        compare(t_name[t], "held resp_user", 64'(held_user[127:64]), 64'(resp_user[127:64]));
        compare(t_name[t], "held resp_time", held_user[63:0], resp_user[63:0]);
        if (resp_ready) begin
          last_code = int'(resp_data[63:32]);
          if (nresp == 0) begin
            first_code = last_code;
            compare(t_name[t], "seqnum", 64'(12'(t * 16 + t_seqp[t])), 64'(resp_data[11:0]));
            compare(t_name[t], "header type", 64'(3), 64'(resp_user[127:126]));
            compare(t_name[t], "has time", 64'(1), 64'(resp_user[125]));
            compare(t_name[t], "error flag", 64'(t_code[t] != 1), 64'(resp_user[124]));
            compare(t_name[t], "sid", 64'(resp_sid), 64'(resp_user[95:64]));
          end
          nresp++;
          seen = 1'b0;
          fall_pending = 1'b1;
        end else if (stall_left > 0) begin
          stall_left--;
        end
      end
      @(posedge clk);
      #10;
      vita_time++;
      cyc++;
      strobe = (cyc % 3 == 0);
      resp_ready = (stall_left == 0);
      if (xfer) beat++;
      if (beat == t_ur[t] && !ur_done) begin
        hold = 4;
        ur_done = 1'b1;
      end
      drive_beat(t, beat, total);
      if (hold > 0) begin
        hold--;
        tx_valid = 1'b0;
      end
    end
    compare(t_name[t], "response count", 64'(t_nresp[t]), 64'(nresp));
    compare(t_name[t], "sample count", 64'(t_nsamp[t]), 64'(nsamp));
    compare(t_name[t], "first code", 64'(t_code[t]), 64'(first_code));
    if (t_nresp[t] > 1) compare(t_name[t], "last code", 64'(1), 64'(last_code));
    $display("%s: %s (%0d errors)", t_name[t], (row_err == 0) ? "ok" : "FAIL", row_err);
    errors += row_err;
    if (row_err != 0) failed++;
    repeat (5) @(posedge clk);
    #10;
  endtask

  initial begin
    {rst_n, clear, set_stb, tx_last, tx_valid, resp_ready, strobe} = '0;
    set_addr = sr_addr;
    set_data = '0;
    tx_user = '0;
    tx_data = '0;
    vita_time = 64'd1000;
    resp_sid = 32'h0a0b_0c0d;
    repeat (10) @(posedge clk);
    #10 rst_n = 1'b1;
    resp_ready = 1'b1;
    for (int t = 0; t < n_tests; t++) run_test(t);
    $display("Tests: %0d, failed: %0d, errors: %0d", n_tests, failed, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog scaled by the number of table rows
  initial begin
    #(n_tests * cycle_budget * 100);
    $display("Watchdog timeout: the tests did not finish in time");
    $display("Test failed");
    $finish;
  end

endmodule

// File: flist.f
rtl/radio_time_pkg.sv
rtl/tx_resp_pkg.sv
rtl/policy_reg.sv
rtl/burst_tracker.sv
rtl/resp_packet_gen.sv
rtl/tx_control.sv
rtl/tx_frontend.sv
bench/tb_clk_gen.sv
bench/tb_tx_frontend.sv

// File: rtl/burst_tracker.sv
/*
 * Packet boundary tracker for the sample stream
 * Keeps start of packet and the eob flag and seqnum of the packet in flight
 */

module burst_tracker (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    clear,
  input  logic [127:0]            tx_user,
  input  logic                    tx_last,
  input  logic                    tx_valid,
  input  logic                    tx_ready,
  output logic                    sop,
  output logic                    eob_reg,
  output radio_time_pkg::seqnum_t cur_seqnum
);

  logic                    xfer;
  radio_time_pkg::seqnum_t seqnum_in;
  radio_time_pkg::seqnum_t seqnum_reg;

  assign xfer      = tx_valid && tx_ready;
  assign seqnum_in = tx_user[tx_resp_pkg::tuser_seqnum_lsb +: $bits(radio_time_pkg::seqnum_t)];

  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      sop     <= 1'b1;
      eob_reg <= 1'b0;
    end else if (xfer) begin
      if (sop) begin
        eob_reg <= tx_user[tx_resp_pkg::tuser_eob_bit];
      end
      // Single-beat packets stay at start of packet
      sop <= tx_last;
    end
  end

  always_ff @(posedge clk) begin
    if (xfer && sop) begin
      seqnum_reg <= seqnum_in;
    end
  end

  // A waiting first beat shows its own seqnum before it is latched
  assign cur_seqnum = (sop && tx_valid) ? seqnum_in : seqnum_reg;

endmodule

// File: rtl/policy_reg.sv
/*
 * Settings register for the error recovery policy
 * Bit 0 resumes at the next packet, bit 1 at the next burst
 */

module policy_reg #(
  parameter logic [7:0] sr_error_policy = 8'd0
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        clear,
  input  logic        set_stb,
  input  logic [7:0]  set_addr,
  input  logic [31:0] set_data,
  output logic        policy_next_packet,
  output logic        policy_next_burst
);

  // Default is to recover at the next packet
  localparam logic [1:0] policy_default = 2'(1) << tx_resp_pkg::policy_next_packet_bit;

  logic [1:0] policy;

  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      policy <= policy_default;
    end else if (set_stb && (set_addr == sr_error_policy)) begin
      policy <= set_data[1:0];
    end
  end

  assign policy_next_packet = policy[tx_resp_pkg::policy_next_packet_bit];
  assign policy_next_burst  = policy[tx_resp_pkg::policy_next_burst_bit];

endmodule

// File: rtl/radio_time_pkg.sv
/*
 * Radio time, stream ID, sample and sequence number types
 * shared by the transmit frontend and its testbench
 */

package radio_time_pkg;

  // Radio time counted in sample ticks
  typedef logic [63:0] vita_time_t;

  // Stream ID carried in response headers
  typedef logic [31:0] sid_t;

  // One complex sample, I in the upper half and Q in the lower half
  typedef logic [31:0] sample_t;

  // Packet sequence number
  typedef logic [11:0] seqnum_t;

endpackage

// File: rtl/resp_packet_gen.sv
/*
 * Response beat builder
 * Forms code word and header on a fire pulse and holds the beat
 * on the response stream until it is accepted
 */

module resp_packet_gen (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       clear,
  input  logic                       resp_fire,
  input  tx_resp_pkg::resp_code_t    resp_code,
  input  radio_time_pkg::seqnum_t    cur_seqnum,
  input  radio_time_pkg::sid_t       resp_sid,
  input  radio_time_pkg::vita_time_t vita_time,
  output logic [63:0]                resp_data,
  output logic [127:0]               resp_user,
  output logic                       resp_last,
  output logic                       resp_valid,
  input  logic                       resp_ready
);

  logic [63:0]  data_next;
  logic [127:0] hdr_next;

  // Code in the upper word, seqnum in the low bits
  assign data_next = {resp_code, 20'd0, cur_seqnum};

  always_comb begin
    hdr_next = '0;
    hdr_next[tx_resp_pkg::resp_type_lsb +: 2] = tx_resp_pkg::resp_pkt_type;
    hdr_next[tx_resp_pkg::resp_has_time_bit]  = 1'b1;
    hdr_next[tx_resp_pkg::resp_is_error_bit]  = (resp_code != tx_resp_pkg::code_eob_ack);
    hdr_next[tx_resp_pkg::resp_sid_lsb +: $bits(radio_time_pkg::sid_t)] = resp_sid;
    hdr_next[tx_resp_pkg::resp_time_lsb +: $bits(radio_time_pkg::vita_time_t)] = vita_time;
  end

  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      resp_valid <= 1'b0;
      resp_last  <= 1'b0;
    end else if (resp_fire) begin
      // A new event replaces a beat that is still waiting
      resp_valid <= 1'b1;
      resp_last  <= 1'b1;
    end else if (resp_valid && resp_ready) begin
      resp_valid <= 1'b0;
      resp_last  <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (resp_fire) begin
      resp_data <= data_next;
      resp_user <= hdr_next;
    end
  end

endmodule

// File: rtl/tx_control.sv
/*
 * Transmit controller FSM
 * Schedules timed and untimed bursts, paces samples by the radio strobe,
 * and raises eob acks, underrun and late-command responses
 */

module tx_control (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       clear,
  input  radio_time_pkg::vita_time_t vita_time,
  input  logic [127:0]               tx_user,
  input  logic                       tx_last,
  input  logic                       tx_valid,
  output logic                       tx_ready,
  output logic                       run,
  input  logic                       strobe,
  input  logic                       sop,
  input  logic                       eob_reg,
  input  logic                       policy_next_packet,
  input  logic                       policy_next_burst,
  output logic                       resp_fire,
  output tx_resp_pkg::resp_code_t    resp_code
);

  tx_resp_pkg::tx_state_e     state;
  tx_resp_pkg::tx_state_e     state_next;
  radio_time_pkg::vita_time_t send_time;
  logic                       send_at;
  logic                       now;
  logic                       late;
  logic                       pkt_eob;
  logic                       at_boundary;
  logic                       policy_resume;

  assign send_time = tx_user[tx_resp_pkg::tuser_time_lsb +: $bits(radio_time_pkg::vita_time_t)];
  assign send_at   = tx_user[tx_resp_pkg::tuser_send_at_bit];

  // Send time compare against the radio clock
  assign now  = (vita_time == send_time);
  assign late = (vita_time > send_time);

  // Header flags are only on the bus for a waiting first beat
  assign pkt_eob = (tx_valid && sop) ? tx_user[tx_resp_pkg::tuser_eob_bit] : eob_reg;

  // End of a packet, or no packet under way
  assign at_boundary   = (tx_valid && tx_last) || (!tx_valid && sop);
  assign policy_resume = policy_next_packet || (policy_next_burst && pkt_eob);

  always_comb begin
    state_next = state;
    resp_fire  = 1'b0;
    resp_code  = tx_resp_pkg::code_eob_ack;
    case (state)
      tx_resp_pkg::st_idle: begin
        if (tx_valid) begin
          if (!send_at || now) begin
            state_next = tx_resp_pkg::st_samp;
          end else if (late) begin
            resp_fire  = 1'b1;
            resp_code  = tx_resp_pkg::code_time_error;
            state_next = tx_resp_pkg::st_error_wait;
          end
        end
      end
      tx_resp_pkg::st_samp: begin
        if (strobe) begin
          if (!tx_valid) begin
            resp_fire  = 1'b1;
            resp_code  = tx_resp_pkg::code_underrun;
            state_next = tx_resp_pkg::st_error_wait;
          end else if (tx_last && pkt_eob) begin
            resp_fire  = 1'b1;
            state_next = tx_resp_pkg::st_idle;
          end
        end
      end
      tx_resp_pkg::st_error_wait: begin
        if (at_boundary && policy_resume) begin
          state_next = tx_resp_pkg::st_idle;
        end
      end
      default: state_next = tx_resp_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      state <= tx_resp_pkg::st_idle;
    end else begin
      state <= state_next;
    end
  end

  // Run drops in the same cycle as an underrun strobe
  assign run = (state == tx_resp_pkg::st_samp) && !(strobe && !tx_valid);

  // Take one beat per strobe while playing, drain everything after an error
  assign tx_ready = (state == tx_resp_pkg::st_error_wait) ||
                    (strobe && (state == tx_resp_pkg::st_samp));

endmodule

// File: rtl/tx_frontend.sv
/*
 * Transmit frontend top level
 * Error policy register, packet tracker, controller FSM and response builder
 */

module tx_frontend #(
  parameter logic [7:0] sr_error_policy = 8'd0
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       clear,
  input  radio_time_pkg::vita_time_t vita_time,
  input  radio_time_pkg::sid_t       resp_sid,
  input  logic                       set_stb,
  input  logic [7:0]                 set_addr,
  input  logic [31:0]                set_data,
  input  radio_time_pkg::sample_t    tx_data,
  input  logic [127:0]               tx_user,
  input  logic                       tx_last,
  input  logic                       tx_valid,
  output logic                       tx_ready,
  output logic [63:0]                resp_data,
  output logic [127:0]               resp_user,
  output logic                       resp_last,
  output logic                       resp_valid,
  input  logic                       resp_ready,
  output logic                       run,
  output radio_time_pkg::sample_t    sample,
  input  logic                       strobe
);

  logic                    policy_next_packet;
  logic                    policy_next_burst;
  logic                    sop;
  logic                    eob_reg;
  radio_time_pkg::seqnum_t cur_seqnum;
  logic                    resp_fire;
  tx_resp_pkg::resp_code_t resp_code;

  // Radio reads the head of the stream directly
  assign sample = tx_data;

  policy_reg #(
    .sr_error_policy(sr_error_policy)
  ) policy_reg_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .clear             (clear),
    .set_stb           (set_stb),
    .set_addr          (set_addr),
    .set_data          (set_data),
    .policy_next_packet(policy_next_packet),
    .policy_next_burst (policy_next_burst)
  );

  burst_tracker burst_tracker_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear     (clear),
    .tx_user   (tx_user),
    .tx_last   (tx_last),
    .tx_valid  (tx_valid),
    .tx_ready  (tx_ready),
    .sop       (sop),
    .eob_reg   (eob_reg),
    .cur_seqnum(cur_seqnum)
  );

  tx_control tx_control_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .clear             (clear),
    .vita_time         (vita_time),
    .tx_user           (tx_user),
    .tx_last           (tx_last),
    .tx_valid          (tx_valid),
    .tx_ready          (tx_ready),
    .run               (run),
    .strobe            (strobe),
    .sop               (sop),
    .eob_reg           (eob_reg),
    .policy_next_packet(policy_next_packet),
    .policy_next_burst (policy_next_burst),
    .resp_fire         (resp_fire),
    .resp_code         (resp_code)
  );

  resp_packet_gen resp_packet_gen_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear     (clear),
    .resp_fire (resp_fire),
    .resp_code (resp_code),
    .cur_seqnum(cur_seqnum),
    .resp_sid  (resp_sid),
    .vita_time (vita_time),
    .resp_data (resp_data),
    .resp_user (resp_user),
    .resp_last (resp_last),
    .resp_valid(resp_valid),
    .resp_ready(resp_ready)
  );

endmodule

// File: rtl/tx_resp_pkg.sv
/*
 * Response codes, error policy bits, tx_user and response
 * header field positions, and the transmit controller states
 */

package tx_resp_pkg;

  typedef logic [31:0] resp_code_t;

  // Response codes returned to the host
  localparam resp_code_t code_eob_ack    = 32'd1;
  localparam resp_code_t code_underrun   = 32'd2;
  localparam resp_code_t code_time_error = 32'd8;

  // Bits of the two-bit error policy register
  localparam int policy_next_packet_bit = 0;
  localparam int policy_next_burst_bit  = 1;

  // Side-band header fields on the sample stream
  localparam int tuser_time_lsb    = 0;
  localparam int tuser_seqnum_lsb  = 112;
  localparam int tuser_eob_bit     = 124;
  localparam int tuser_send_at_bit = 125;

  // Response header layout
  localparam logic [1:0] resp_pkt_type = 2'b11;
  localparam int resp_type_lsb      = 126;
  localparam int resp_has_time_bit  = 125;
  localparam int resp_is_error_bit  = 124;
  localparam int resp_sid_lsb       = 64;
  localparam int resp_time_lsb      = 0;

  // Transmit controller states
  typedef enum logic [1:0] {
    st_idle,
    st_samp,
    st_error_wait
  } tx_state_e;

endpackage

// File: run_sim.sh
#!/bin/sh
# Build and run the transmit frontend testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_tx_frontend -f flist.f -o sim_tx_frontend
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tx_frontend > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" sim.log; then
  exit 1
fi
exit 0
